/* Makefile */
SIM  := obj_dir/Vtb_network
SRCS := $(wildcard design/*.sv tb/*.sv)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_network -f verilog.f

run: $(SIM)
	./$(SIM) | tee sim.log

# pass only if the log holds the pass line
check: run
	@grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* design/cnn_layer.sv */
`timescale 1ns/1ps

module cnn_layer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  net_pkg::layer_ctrl_t ctrl,
  input  net_pkg::feat_vec_t   d,
  output logic                 layer_done,
  output net_pkg::feat_vec_t   q
);

  // pass setup latched on start
  net_pkg::layer_idx_t layer_r;
  logic                act_r;

  // sequencing
  logic                run;
  logic                wb;
  net_pkg::feat_idx_t  neuron;
  net_pkg::feat_idx_t  index;

  // datapath
  logic signed [net_pkg::acc_len-1:0] acc;
  logic signed [net_pkg::acc_len-1:0] prod;
  logic signed [net_pkg::acc_len-1:0] shifted;
  logic signed [3:0]                  w;
  net_pkg::feat_t                     x;
  net_pkg::feat_t                     sat;
  net_pkg::feat_t                     res;

  // source copy for the pass, hidden results from the last pass
  net_pkg::feat_vec_t src;
  net_pkg::feat_vec_t hid;

  weight_rom weight_rom_inst (
    .layer(layer_r),
    .neuron(neuron),
    .index(index),
    .w(w)
  );

  // one signed mac per cycle
  assign x    = src[index];
  assign prod = w * x;

  // scale, clamp to 8 bits, then the cheap elu
  always_comb begin
    shifted = acc >>> net_pkg::acc_shift;
    if (shifted > 127) begin
      sat = 8'sd127;
    end else if (shifted < -128) begin
      sat = -8'sd128;
    end else begin
      sat = shifted[net_pkg::data_len-1:0];
    end
    // negative side only gets shrunk
    if (act_r && (sat < 0)) begin
      res = sat >>> net_pkg::elu_shift;
    end else begin
      res = sat;
    end
  end

  // done in the writeback cycle of neuron 11
  assign layer_done = run & wb & (neuron == net_pkg::last_feat);

  // counters and accumulator
  // per neuron: 12 mac cycles then 1 writeback
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_r <= '0;
      act_r   <= 1'b0;
      run     <= 1'b0;
      wb      <= 1'b0;
      neuron  <= '0;
      index   <= '0;
      acc     <= '0;
    end else if (ctrl.start) begin
      layer_r <= ctrl.layer;
      act_r   <= ctrl.activate;
      run     <= 1'b1;
      wb      <= 1'b0;
      neuron  <= '0;
      index   <= '0;
      acc     <= '0;
    end else if (run) begin
      if (wb) begin
        // result leaves this cycle, restart for the next neuron
        acc   <= '0;
        index <= '0;
        wb    <= 1'b0;
        if (neuron == net_pkg::last_feat) begin
          run    <= 1'b0;
          neuron <= '0;
        end else begin
          neuron <= neuron + 1'b1;
        end
      end else begin
        acc <= acc + prod;
        if (index == net_pkg::last_feat) wb <= 1'b1;
        else index <= index + 1'b1;
      end
    end
  end

  // ping-pong storage
  // hidden passes go to hid, the affine pass goes to q
  // so the scores only move during affine
  always_ff @(posedge clk) begin
    if (ctrl.start) begin
      src <= ctrl.from_buffer ? d : hid;
    end
    if (run && wb) begin
      if (layer_r == net_pkg::affine_layer) begin
        q[neuron] <= res;
      end else begin
        hid[neuron] <= res;
      end
    end
  end

endmodule

/* design/comp_layer.sv */
`timescale 1ns/1ps

module comp_layer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               comp_start,
  input  net_pkg::feat_vec_t d,
  output logic               comp_done,
  output logic [3:0]         q
);

  net_pkg::feat_idx_t idx;
  net_pkg::feat_idx_t best_i;
  logic               run;
  // running maximum
  net_pkg::feat_t     best;
  net_pkg::feat_t     x;
  logic               take;

  assign x = d[idx];

  // first score always taken
  // strict compare keeps the lower index on a tie
  assign take = (idx == '0) || (x > best);

  // one score per cycle, done 13 cycles after start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx       <= '0;
      best_i    <= '0;
      run       <= 1'b0;
      comp_done <= 1'b0;
      q         <= '0;
    end else begin
      comp_done <= 1'b0;
      if (comp_start) begin
        run <= 1'b1;
        idx <= '0;
      end else if (run) begin
        if (take) best_i <= idx;
        if (idx == net_pkg::last_feat) begin
          run       <= 1'b0;
          comp_done <= 1'b1;
          // include the last score in the result
          q         <= take ? idx : best_i;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run && take) best <= x;
  end

endmodule

/* design/cube_data_buffer.sv */
`timescale 1ns/1ps

module cube_data_buffer (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          beat,
  input  logic [net_pkg::beat_lanes*net_pkg::data_len-1:0] d,
  output net_pkg::feat_vec_t                            q
);

  // next four-feature slot to fill
  net_pkg::beat_idx_t slot;

  // slot pointer, wraps after the third beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot <= '0;
    end else if (beat) begin
      if (slot == net_pkg::last_beat) slot <= '0;
      else slot <= slot + 1'b1;
    end
  end

  // lane k of beat b is feature 4b+k
  // vector held until the next frame overwrites it
  always_ff @(posedge clk) begin
    if (beat) begin
      for (int k = 0; k < net_pkg::beat_lanes; k++) begin
        q[slot*net_pkg::beat_lanes + k] <= d[k*net_pkg::data_len +: net_pkg::data_len];
      end
    end
  end

endmodule

/* design/net_pkg.sv */
package net_pkg;

  // feature and vector geometry
  localparam int data_len   = 8;
  localparam int n_feat     = 12;
  localparam int beat_lanes = 4;
  localparam int n_beats    = 3;

  // mac datapath
  localparam int acc_len   = 20;
  // accumulator scale down before saturation
  localparam int acc_shift = 4;
  // slope of the negative side of the activation
  localparam int elu_shift = 2;

  // four hidden passes plus the affine pass
  localparam int n_layers = 5;

  // one signed feature
  typedef logic signed [data_len-1:0] feat_t;

  // feature 0 in the low byte
  typedef feat_t [n_feat-1:0] feat_vec_t;

  // counters over features, beats and layers
  typedef logic [3:0] feat_idx_t;
  typedef logic [1:0] beat_idx_t;
  typedef logic [2:0] layer_idx_t;

  localparam feat_idx_t  last_feat    = feat_idx_t'(n_feat - 1);
  localparam beat_idx_t  last_beat    = beat_idx_t'(n_beats - 1);
  localparam layer_idx_t affine_layer = layer_idx_t'(n_layers - 1);

  // sequencer states
  typedef enum logic [3:0] {
    LIDLE, BUFFER, LAYER0, LAYER1, LAYER2, LAYER3, AFFINE, COMP, LFIN
  } state_t;

  // sequencer to layer engine
  typedef struct packed {
    // one cycle, begins a pass
    logic       start;
    logic [2:0] layer;
    // source is the cube buffer, not the engine's own results
    logic       from_buffer;
    // clear for the affine pass
    logic       activate;
  } layer_ctrl_t;

endpackage

/* design/network.sv */
`timescale 1ns/1ps

module network (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             load,
  input  logic [net_pkg::beat_lanes*net_pkg::data_len-1:0] d,
  output logic                                             busy,
  output logic                                             valid,
  output logic [3:0]                                       q,
  output net_pkg::feat_vec_t                               scores
);

  // sequencer outputs
  logic                 beat;
  net_pkg::layer_ctrl_t ctrl;
  logic                 comp_start;

  // cube buffer to layer engine
  net_pkg::feat_vec_t   bufout;

  // engine and compare handshakes
  logic                 layer_done;
  logic                 comp_done;

  state_layer state_layer_inst (
    .clk(clk),
    .rst_n(rst_n),
    .load(load),
    .layer_done(layer_done),
    .comp_done(comp_done),
    .beat(beat),
    .ctrl(ctrl),
    .comp_start(comp_start),
    .busy(busy),
    .valid(valid)
  );

  cube_data_buffer cube_data_buffer_inst (
    .clk(clk),
    .rst_n(rst_n),
    .beat(beat),
    .d(d),
    .q(bufout)
  );

  // one engine reused for all five passes
  cnn_layer cnn_layer_inst (
    .clk(clk),
    .rst_n(rst_n),
    .ctrl(ctrl),
    .d(bufout),
    .layer_done(layer_done),
    .q(scores)
  );

  // argmax over the affine scores
  comp_layer comp_layer_inst (
    .clk(clk),
    .rst_n(rst_n),
    .comp_start(comp_start),
    .d(scores),
    .comp_done(comp_done),
    .q(q)
  );

endmodule

/* design/state_layer.sv */
`timescale 1ns/1ps

module state_layer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 layer_done,
  input  logic                 comp_done,
  output logic                 beat,
  output net_pkg::layer_ctrl_t ctrl,
  output logic                 comp_start,
  output logic                 busy,
  output logic                 valid
);

  net_pkg::state_t    cs;
  net_pkg::state_t    cs_next;
  net_pkg::beat_idx_t beat_cnt;
  logic               start_r;

  // input beats only accepted while idle or collecting
  assign beat = load & ((cs == net_pkg::LIDLE) | (cs == net_pkg::BUFFER));

  // next state
  always_comb begin
    cs_next = cs;
    case (cs)
      net_pkg::LIDLE: begin
        // load in idle is beat 0
        if (load) cs_next = net_pkg::BUFFER;
      end
      net_pkg::BUFFER: begin
        if (load && (beat_cnt == net_pkg::last_beat)) cs_next = net_pkg::LAYER0;
      end
      net_pkg::LAYER0: if (layer_done) cs_next = net_pkg::LAYER1;
      net_pkg::LAYER1: if (layer_done) cs_next = net_pkg::LAYER2;
      net_pkg::LAYER2: if (layer_done) cs_next = net_pkg::LAYER3;
      net_pkg::LAYER3: if (layer_done) cs_next = net_pkg::AFFINE;
      net_pkg::AFFINE: if (layer_done) cs_next = net_pkg::COMP;
      net_pkg::COMP:   if (comp_done) cs_next = net_pkg::LFIN;
      default:         cs_next = net_pkg::LIDLE;
    endcase
  end

  // state, beat count and start pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs         <= net_pkg::LIDLE;
      beat_cnt   <= '0;
      start_r    <= 1'b0;
      comp_start <= 1'b0;
    end else begin
      cs <= cs_next;
      // counts 0..2, back to 0 after the last beat
      if (beat) begin
        if (beat_cnt == net_pkg::last_beat) beat_cnt <= '0;
        else beat_cnt <= beat_cnt + 1'b1;
      end
      // pulse in the first cycle of each layer state
      start_r <= (cs_next != cs) &&
                 (cs_next inside {net_pkg::LAYER0, net_pkg::LAYER1, net_pkg::LAYER2,
                                  net_pkg::LAYER3, net_pkg::AFFINE});
      comp_start <= (cs_next == net_pkg::COMP) && (cs != net_pkg::COMP);
    end
  end

  // layer control decoded from state
  always_comb begin
    ctrl.start       = start_r;
    ctrl.from_buffer = (cs == net_pkg::LAYER0);
    ctrl.activate    = (cs != net_pkg::AFFINE);
    case (cs)
      net_pkg::LAYER1: ctrl.layer = 3'd1;
      net_pkg::LAYER2: ctrl.layer = 3'd2;
      net_pkg::LAYER3: ctrl.layer = 3'd3;
      net_pkg::AFFINE: ctrl.layer = net_pkg::affine_layer;
      default:         ctrl.layer = 3'd0;
    endcase
  end

  // busy drops the cycle after the valid pulse
  assign busy  = (cs != net_pkg::LIDLE);
  assign valid = (cs == net_pkg::LFIN);

endmodule

/* design/weight_rom.sv */
`timescale 1ns/1ps

module weight_rom (
  input  logic [2:0]        layer,
  input  logic [3:0]        neuron,
  input  logic [3:0]        index,
  output logic signed [3:0] w
);

  // raw sum, at most 116
  int sum;
  int m;

  // w = ((7*layer + 5*neuron + 3*index) mod 9) - 4
  // spans -4..+4
  always_comb begin
    sum = 7 * int'(layer) + 5 * int'(neuron) + 3 * int'(index);
    m   = sum % 9;
    w   = 4'(m - 4);
  end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

/* tb/network_checker.sv */
`timescale 1ns/1ps

module network_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load,
  input  logic [31:0]        d,
  input  logic               busy,
  input  logic               valid,
  input  logic [3:0]         q,
  input  net_pkg::feat_vec_t scores,
  output int                 error_count,
  output int                 check_count,
  output int                 frame_count
);

  // set by the tb top before each frame
  string test_name = "none";
  // name of the frame now in flight
  string frame_name = "none";

  int   frame_in [12];
  int   exp_scores [12];
  int   exp_q;
  int   beat_no;
  logic in_frame;

  initial begin
    error_count = 0;
    check_count = 0;
    frame_count = 0;
    beat_no     = 0;
    in_frame    = 1'b0;
  end

  // weight table: ((7L + 5o + 3i) mod 9) - 4
  function automatic int weight(input int layer, input int o, input int i);
    return ((7 * layer + 5 * o + 3 * i) % 9) - 4;
  endfunction

  // integer model of all five passes plus argmax
  task automatic run_model();
    int x [12];
    int y [12];
    int acc;
    int v;
    int l;
    int o;
    int i;
    x = frame_in;
    for (l = 0; l < 5; l++) begin
      for (o = 0; o < 12; o++) begin
        acc = 0;
        for (i = 0; i < 12; i++) acc += weight(l, o, i) * x[i];
        // floor divide by 16, clamp to a signed byte
        v = acc >>> 4;
        if (v > 127) v = 127;
        else if (v < -128) v = -128;
        // hidden layers shrink the negative side by 4
        if (l < 4 && v < 0) v = v >>> 2;
        y[o] = v;
      end
      x = y;
    end
    exp_scores = x;
    // lowest index kept on ties
    exp_q = 0;
    for (o = 1; o < 12; o++) begin
      if (x[o] > x[exp_q]) exp_q = o;
    end
  endtask

  task automatic compare_results();
    int o;
    for (o = 0; o < 12; o++) begin
      check_count++;
      if (scores[o] !== net_pkg::feat_t'(exp_scores[o])) begin
        error_count++;
        $display("FAILED %s score[%0d]: expected %0d, actual %0d",
                 frame_name, o, exp_scores[o], $signed(scores[o]));
      end
    end
    check_count++;
    if (q !== 4'(exp_q)) begin
      error_count++;
      $display("FAILED %s q: expected %0d, actual %0d", frame_name, exp_q, q);
    end
    frame_count++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      in_frame = 1'b0;
      beat_no  = 0;
    end else begin
      // busy lags the accepted beat 0 and the valid pulse by one cycle
      check_count++;
      if (busy !== in_frame) begin
        error_count++;
        $display("FAILED %s busy: expected %b, actual %b", test_name, in_frame, busy);
      end
      // frames offered while busy are dropped
      if (load === 1'b1 && (beat_no > 0 || !in_frame)) begin
        if (beat_no == 0) begin
          frame_name = test_name;
          in_frame   = 1'b1;
        end
        for (int k = 0; k < 4; k++) frame_in[4 * beat_no + k] = $signed(d[8 * k +: 8]);
        beat_no++;
        if (beat_no == 3) begin
          run_model();
          beat_no = 0;
        end
      end
      if (valid === 1'b1) begin
        if (!in_frame || beat_no != 0) begin
          error_count++;
          $display("valid pulse seen with no frame pending, test %s", test_name);
        end else begin
          compare_results();
        end
        in_frame = 1'b0;
      end else if (valid !== 1'b0) begin
        error_count++;
        $display("valid is unknown during test %s", test_name);
      end
    end
  end

endmodule

/* tb/tb_network.sv */
`timescale 1ns/1ps

module tb_network;

  localparam int valid_timeout = 2000;
  localparam int idle_timeout  = 2000;
  localparam int n_random      = 20;

  logic               clk;
  logic               rst_n;
  logic               load;
  logic [31:0]        d;
  logic               busy;
  logic               valid;
  logic [3:0]         q;
  net_pkg::feat_vec_t scores;

  int error_count;
  int check_count;
  int frame_count;
  int tb_errors;
  int frames_expected;

  clk_gen i_clk_gen (
    .clk(clk)
  );

  network i_network (
    .clk(clk),
    .rst_n(rst_n),
    .load(load),
    .d(d),
    .busy(busy),
    .valid(valid),
    .q(q),
    .scores(scores)
  );

  network_checker i_checker (
    .clk(clk),
    .rst_n(rst_n),
    .load(load),
    .d(d),
    .busy(busy),
    .valid(valid),
    .q(q),
    .scores(scores),
    .error_count(error_count),
    .check_count(check_count),
    .frame_count(frame_count)
  );

  function automatic net_pkg::feat_vec_t random_frame();
    net_pkg::feat_vec_t f;
    for (int k = 0; k < 12; k++) f[k] = net_pkg::feat_t'($urandom);
    return f;
  endfunction

  // three load cycles, 1 ns after the edge
  task automatic send_frame(input net_pkg::feat_vec_t frame, input string name);
    int b;
    i_checker.test_name = name;
    for (b = 0; b < 3; b++) begin
      @(posedge clk);
      #1;
      load = 1'b1;
      d    = frame[4 * b +: 4];
    end
    @(posedge clk);
    #1;
    load = 1'b0;
    d    = '0;
  endtask

  task automatic wait_valid(input string name);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < valid_timeout) begin
      @(posedge clk);
      #1;
      seen = (valid === 1'b1);
      n++;
    end
    if (!seen) begin
      tb_errors++;
      $display("timeout: no valid pulse within %0d cycles in test %s", valid_timeout, name);
    end
  endtask

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (busy !== 1'b0 && n < idle_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy !== 1'b0) begin
      tb_errors++;
      $display("timeout: DUT still busy after %0d cycles in test %s", idle_timeout, name);
    end
  endtask

  task automatic run_frame(input net_pkg::feat_vec_t frame, input string name);
    wait_idle(name);
    send_frame(frame, name);
    frames_expected++;
    wait_valid(name);
  endtask

  initial begin
    load            = 1'b0;
    d               = '0;
    rst_n           = 1'b0;
    tb_errors       = 0;
    frames_expected = 0;
    void'($urandom(32'h76aa58a5));
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // no frame yet, busy and valid must stay low
    i_checker.test_name = "reset";
    repeat (20) @(posedge clk);

    // all scores zero, index 0 wins the tie
    run_frame('0, "zero_tie");
    run_frame({12{8'h7f}}, "sat_pos");
    // negative hidden values go through the activation
    run_frame({12{8'h80}}, "sat_neg");
    // signs follow layer 0 neuron 0 weights so its sum clips
    run_frame({4{8'h7f, 8'h80, 8'h80}}, "clip_pos");
    // same neuron driven below -128 before the activation
    run_frame({4{8'h80, 8'h7f, 8'h7f}}, "clip_neg");
    for (int k = 0; k < n_random; k++) run_frame(random_frame(), "random");

    // second frame lands mid-pass and must vanish
    wait_idle("dropped");
    send_frame(random_frame(), "dropped");
    frames_expected++;
    repeat (50) @(posedge clk);
    #1;
    if (busy !== 1'b1) begin
      tb_errors++;
      $display("DUT was not busy when the extra frame was offered");
    end
    send_frame(random_frame(), "dropped_extra");
    wait_valid("dropped");
    // room for a stray valid to show up
    repeat (200) @(posedge clk);

    if (frame_count != frames_expected) begin
      tb_errors++;
      $display("only %0d of %0d frames reached the checker", frame_count, frames_expected);
    end
    $display("checks %0d, frames %0d, checker errors %0d, testbench errors %0d",
             check_count, frame_count, error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/net_pkg.sv
design/weight_rom.sv
design/state_layer.sv
design/cube_data_buffer.sv
design/cnn_layer.sv
design/comp_layer.sv
design/network.sv
tb/clk_gen.sv
tb/network_checker.sv
tb/tb_network.sv
